// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_fpu_i2f
FILELIST    ?= fpu_i2f_axil_top.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS  ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== fpu_i2f_axil_top.f ====
+incdir+verification
logic/fpu_pkg.sv
logic/fpu_round_n.sv
logic/fpu_i2f_normalize.sv
logic/fpu_i2f.sv
logic/fpu_axil_regs.sv
logic/fpu_i2f_axil_top.sv
verification/tb_fpu_i2f.sv

// ==== logic/fpu_axil_regs.sv ====
module fpu_axil_regs import fpu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // write address and data, accepted together
  input  logic [3:0]                  awaddr_i,
  input  logic                        awvalid_i,
  output logic                        awready_o,
  input  logic [31:0]                 wdata_i,
  input  logic                        wvalid_i,
  output logic                        wready_o,
  // write response
  output logic                        bvalid_o,
  output logic [1:0]                  bresp_o,
  input  logic                        bready_i,
  // read address and data
  input  logic [3:0]                  araddr_i,
  input  logic                        arvalid_i,
  output logic                        arready_o,
  output logic                        rvalid_o,
  output logic [31:0]                 rdata_o,
  output logic [1:0]                  rresp_o,
  input  logic                        rready_i,
  // converter side
  output logic                        start_o,
  output logic [fpu_int_width_c-1:0]  operand_o,
  output fpu_rounding_type_e          mode_o,
  input  logic                        conv_valid_i,
  input  logic [31:0]                 conv_result_i,
  input  logic                        conv_inexact_i
);

  localparam logic [1:0] resp_okay_lp   = 2'b00;
  localparam logic [1:0] resp_slverr_lp = 2'b10;

  fpu_rounding_type_e         ctrl_r;
  logic [fpu_int_width_c-1:0] operand_r;
  logic [31:0]                result_r;
  logic                       busy_r;
  logic                       inexact_r;
  logic                       done_r;

  logic                       aw_hs;
  logic                       ar_hs;
  logic                       wr_ok;
  logic                       rd_ok;
  logic [31:0]                rd_data;

  // --------------------------------------------------------------------------
  // handshakes and decode
  // --------------------------------------------------------------------------

  // aw and w together, stalled while a response waits or a conversion runs
  assign aw_hs     = awvalid_i & wvalid_i & ~bvalid_o & ~busy_r;
  assign awready_o = aw_hs;
  assign wready_o  = aw_hs;
  assign ar_hs     = arvalid_i & arready_o;

  assign operand_o = operand_r;
  assign mode_o    = ctrl_r;

  // only ctrl and operand are writable
  always_comb begin
    case (fpu_reg_addr_e'(awaddr_i))
      e_reg_ctrl, e_reg_operand: wr_ok = 1'b1;
      default:                   wr_ok = 1'b0;
    endcase
  end

  // read mux, unknown addresses give zero data
  always_comb begin
    rd_ok   = 1'b1;
    rd_data = '0;
    case (fpu_reg_addr_e'(araddr_i))
      e_reg_ctrl:    rd_data = {29'b0, ctrl_r};
      e_reg_operand: rd_data = operand_r;
      e_reg_result:  rd_data = result_r;
      e_reg_status:  rd_data = {29'b0, done_r, inexact_r, busy_r};
      default:       rd_ok   = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // registers and channel state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_r    <= e_rne;
      operand_r <= '0;
      result_r  <= '0;
      busy_r    <= 1'b0;
      inexact_r <= 1'b0;
      done_r    <= 1'b0;
      start_o   <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      arready_o <= 1'b0;
    end else begin
      // single cycle pulse
      start_o <= 1'b0;

      if (aw_hs) begin
        bvalid_o <= 1'b1;
        if (fpu_reg_addr_e'(awaddr_i) == e_reg_ctrl) begin
          // undefined codes stored as written
          ctrl_r <= fpu_rounding_type_e'(wdata_i[2:0]);
        end
        if (fpu_reg_addr_e'(awaddr_i) == e_reg_operand) begin
          operand_r <= wdata_i;
          start_o   <= 1'b1;
          busy_r    <= 1'b1;
          done_r    <= 1'b0;
        end
      end else if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end

      // result comes back 2 cycles after start, never overlaps a write
      if (conv_valid_i) begin
        result_r  <= conv_result_i;
        inexact_r <= conv_inexact_i;
        done_r    <= 1'b1;
        busy_r    <= 1'b0;
      end

      // one read outstanding, arready drops while r is held
      if (ar_hs) begin
        rvalid_o  <= 1'b1;
        arready_o <= 1'b0;
      end else if (!rvalid_o || rready_i) begin
        rvalid_o  <= 1'b0;
        arready_o <= 1'b1;
      end
    end
  end

  // response payload, stable while valid is held
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      bresp_o <= wr_ok ? resp_okay_lp : resp_slverr_lp;
    end
    if (ar_hs) begin
      rdata_o <= rd_data;
      rresp_o <= rd_ok ? resp_okay_lp : resp_slverr_lp;
    end
  end

endmodule

// ==== logic/fpu_i2f.sv ====
module fpu_i2f import fpu_pkg::*; #(
  parameter int width_i_p = 32,
  parameter int width_o_p = 24
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  logic [fpu_int_width_c-1:0]  operand_i,
  input  fpu_rounding_type_e          mode_i,
  output logic                        valid_o,
  output logic [31:0]                 result_o,
  output logic                        inexact_o
);

  // stage 1 outputs
  logic                       s1_valid;
  logic                       s1_sign;
  logic                       s1_zero;
  logic [fpu_exp_width_c-1:0] s1_exp;
  logic [width_i_p-1:0]       s1_mantissa;
  fpu_rounding_type_e         s1_mode;

  // rounder outputs
  logic [width_o_p-1:0]       rnd_mantissa;
  logic                       rnd_carry;
  logic                       rnd_inexact;

  logic [fpu_exp_width_c-1:0] exp_d;
  logic [width_o_p-1:0]       sig_d;

  // --------------------------------------------------------------------------
  // stage 1: absolute value and normalize
  // --------------------------------------------------------------------------

  fpu_i2f_normalize u_normalize (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .operand_i  (operand_i),
    .mode_i     (mode_i),
    .valid_o    (s1_valid),
    .sign_o     (s1_sign),
    .zero_o     (s1_zero),
    .exp_o      (s1_exp),
    .mantissa_o (s1_mantissa),
    .mode_o     (s1_mode)
  );

  // --------------------------------------------------------------------------
  // stage 2: round and pack
  // --------------------------------------------------------------------------

  fpu_round_n #(
    .width_i_p (width_i_p),
    .width_o_p (width_o_p)
  ) u_round (
    .type_i     (s1_mode),
    .mantissa_i (s1_mantissa),
    .sign_i     (s1_sign),
    .mantissa_o (rnd_mantissa),
    .carry_o    (rnd_carry),
    .inexact_o  (rnd_inexact)
  );

  // all ones rounded up, significand becomes 1.0 and the exponent steps
  assign exp_d = rnd_carry ? (s1_exp + 1'b1) : s1_exp;
  assign sig_d = rnd_carry ? {1'b1, {(width_o_p-1){1'b0}}} : rnd_mantissa;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid) begin
      if (s1_zero) begin
        // integer zero is always +0.0 and exact
        result_o  <= '0;
        inexact_o <= 1'b0;
      end else begin
        // hidden bit dropped
        result_o  <= {s1_sign, exp_d, sig_d[fpu_man_width_c-1:0]};
        inexact_o <= rnd_inexact;
      end
    end
  end

endmodule

// ==== logic/fpu_i2f_axil_top.sv ====
module fpu_i2f_axil_top import fpu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [3:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o,
  output logic [1:0]  bresp_o,
  input  logic        bready_i,
  input  logic [3:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  input  logic        rready_i
);

  // rounder takes the 32 bit normalized magnitude down to a 24 bit significand
  localparam int width_i_lp = 32;
  localparam int width_o_lp = 24;

  logic               start;
  logic [31:0]        operand;
  fpu_rounding_type_e mode;
  logic               conv_valid;
  logic [31:0]        conv_result;
  logic               conv_inexact;

  fpu_axil_regs uut_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bvalid_o       (bvalid_o),
    .bresp_o        (bresp_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .rresp_o        (rresp_o),
    .rready_i       (rready_i),
    .start_o        (start),
    .operand_o      (operand),
    .mode_o         (mode),
    .conv_valid_i   (conv_valid),
    .conv_result_i  (conv_result),
    .conv_inexact_i (conv_inexact)
  );

  fpu_i2f #(
    .width_i_p (width_i_lp),
    .width_o_p (width_o_lp)
  ) uut_conv (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (start),
    .operand_i (operand),
    .mode_i    (mode),
    .valid_o   (conv_valid),
    .result_o  (conv_result),
    .inexact_o (conv_inexact)
  );

endmodule

// ==== logic/fpu_i2f_normalize.sv ====
module fpu_i2f_normalize import fpu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  logic [fpu_int_width_c-1:0]  operand_i,
  input  fpu_rounding_type_e          mode_i,
  output logic                        valid_o,
  output logic                        sign_o,
  output logic                        zero_o,
  output logic [fpu_exp_width_c-1:0]  exp_o,
  output logic [fpu_int_width_c-1:0]  mantissa_o,
  output fpu_rounding_type_e          mode_o
);

  localparam int lzc_width_lp = $clog2(fpu_int_width_c);
  // exponent when the leading one is already at the top bit
  localparam logic [fpu_exp_width_c-1:0] exp_top_lp =
    fpu_exp_width_c'(fpu_exp_bias_c + fpu_int_width_c - 1);

  logic [fpu_int_width_c-1:0] mag;
  logic [lzc_width_lp-1:0]    lzc;

  // --------------------------------------------------------------------------
  // magnitude and leading zero count
  // --------------------------------------------------------------------------

  // two's complement negate, the most negative value comes out as 2^31 unsigned
  assign mag = operand_i[fpu_int_width_c-1] ? (~operand_i + 1'b1) : operand_i;

  // priority count, the highest set bit is visited last and wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < fpu_int_width_c; i++) begin
      if (mag[i]) begin
        lzc = lzc_width_lp'(fpu_int_width_c - 1 - i);
      end
    end
  end

  // --------------------------------------------------------------------------
  // stage register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload only moves when a conversion enters
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sign_o     <= operand_i[fpu_int_width_c-1];
      zero_o     <= (operand_i == '0);
      // leading one lands on the top bit
      mantissa_o <= mag << lzc;
      exp_o      <= exp_top_lp - fpu_exp_width_c'(lzc);
      mode_o     <= mode_i;
    end
  end

endmodule

// ==== logic/fpu_pkg.sv ====
package fpu_pkg;

  // --------------------------------------------------------------------------
  // rounding modes
  // --------------------------------------------------------------------------

  // codes 5 to 7 are kept in ctrl but round like e_rne
  typedef enum logic [2:0] {
    e_rne = 3'd0,
    e_rna = 3'd1,
    e_rtz = 3'd2,
    e_rup = 3'd3,
    e_rdn = 3'd4
  } fpu_rounding_type_e;

  // --------------------------------------------------------------------------
  // register map, byte addresses
  // --------------------------------------------------------------------------

  typedef enum logic [3:0] {
    e_reg_ctrl    = 4'h0,
    e_reg_operand = 4'h4,
    e_reg_result  = 4'h8,
    e_reg_status  = 4'hC
  } fpu_reg_addr_e;

  // --------------------------------------------------------------------------
  // single precision format
  // --------------------------------------------------------------------------

  localparam int fpu_exp_width_c = 8;
  localparam int fpu_man_width_c = 23;
  localparam int fpu_exp_bias_c  = 127;
  // signed integer operand
  localparam int fpu_int_width_c = 32;

endpackage

// ==== logic/fpu_round_n.sv ====
module fpu_round_n import fpu_pkg::*; #(
  parameter int width_i_p = 32,
  parameter int width_o_p = 24
) (
  input  fpu_rounding_type_e     type_i,
  input  logic [width_i_p-1:0]   mantissa_i,
  input  logic                   sign_i,
  output logic [width_o_p-1:0]   mantissa_o,
  output logic                   carry_o,
  output logic                   inexact_o
);

  // number of bits dropped by the rounding
  localparam int diff_lp = width_i_p - width_o_p;

  logic [width_o_p-1:0] kept;
  logic                 guard;
  logic                 sticky;
  logic                 round_up;

  // kept field, then the first dropped bit
  assign kept  = mantissa_i[width_i_p-1:diff_lp];
  assign guard = mantissa_i[diff_lp-1];

  // or of everything below the guard bit
  if (diff_lp > 1) begin : g_sticky
    assign sticky = |mantissa_i[diff_lp-2:0];
  end else begin : g_no_sticky
    assign sticky = 1'b0;
  end

  assign inexact_o = guard | sticky;

  // increment decision on the magnitude, sign only matters for the directed modes
  always_comb begin
    case (type_i)
      e_rna:   round_up = guard;
      e_rtz:   round_up = 1'b0;
      e_rup:   round_up = inexact_o & ~sign_i;
      e_rdn:   round_up = inexact_o & sign_i;
      // e_rne and the undefined codes
      default: round_up = guard & (sticky | kept[0]);
    endcase
  end

  // one extra bit catches overflow of the kept field
  assign {carry_o, mantissa_o} = {1'b0, kept} + (width_o_p+1)'(round_up);

endmodule

// ==== verification/tb_fpu_i2f_ref.svh ====
`ifndef TB_FPU_I2F_REF_SVH
`define TB_FPU_I2F_REF_SVH

// ----------------------------------------------------------------------------
// expected conversion, returns {inexact, float word}
// ----------------------------------------------------------------------------

function automatic logic [32:0] ref_i2f(input logic [31:0] value, input logic [2:0] mode);
  longint mag;
  longint kept;
  longint rem;
  longint frac;
  int     pos;
  int     shift;
  int     exp_v;
  logic   sign;
  logic   guard;
  logic   sticky;
  logic   up;
  sign = value[31];
  mag  = longint'($signed(value));
  if (mag < 0) begin
    mag = -mag;
  end
  if (mag == 0) begin
    return 33'd0;
  end
  // position of the leading one
  pos = 0;
  while ((mag >> (pos + 1)) != 0) begin
    pos++;
  end
  shift  = (pos > fpu_man_width_c) ? pos - fpu_man_width_c : 0;
  kept   = mag >> shift;
  rem    = mag - (kept << shift);
  guard  = 1'b0;
  sticky = 1'b0;
  if (shift > 0) begin
    guard  = rem[shift-1];
    sticky = (rem & ((longint'(1) << (shift - 1)) - 1)) != 0;
  end
  // increment on the magnitude, undefined codes round to nearest even
  case (mode)
    e_rna:   up = guard;
    e_rtz:   up = 1'b0;
    e_rup:   up = (guard | sticky) & ~sign;
    e_rdn:   up = (guard | sticky) & sign;
    default: up = guard & (sticky | kept[0]);
  endcase
  if (shift > 0) begin
    frac = kept + longint'(up);
  end else begin
    frac = mag << (fpu_man_width_c - pos);
  end
  exp_v = fpu_exp_bias_c + pos;
  // rounding past 2.0 moves to the next binade
  if (frac == (longint'(1) << (fpu_man_width_c + 1))) begin
    frac = frac >> 1;
    exp_v++;
  end
  return {guard | sticky, sign, 8'(exp_v), frac[fpu_man_width_c-1:0]};
endfunction

// data words, named by signal
task automatic compare_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("Fail %s expected 0x%08h actual 0x%08h", name, expected, actual));
  end
endtask

// bresp and rresp
task automatic compare_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("Fail %s expected 0x%01h actual 0x%01h", name, expected, actual));
  end
endtask

`endif

// ==== verification/tb_fpu_i2f.sv ====
module tb_fpu_i2f import fpu_pkg::*; ();

  // cycles allowed for any single handshake
  localparam int timeout_lp  = 200;
  // status reads allowed before done
  localparam int poll_max_lp = 50;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  int unsigned cycle;

  // finished conversions waiting for the checker
  logic [31:0] op_q[$];
  logic [2:0]  mode_q[$];
  logic [31:0] res_q[$];
  logic [31:0] stat_q[$];
  event        conv_ev;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  `include "tb_fpu_i2f_ref.svh"

  fpu_i2f_axil_top uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bresp_o   (bresp),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rready_i  (rready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------------------------------------------
  // AXI4-Lite master side with outputs sampled on the falling edge
  // ----------------------------------------------------------------------------

  // aw and w go out together and acc holds the cycle count just before the accepting edge
  task automatic send_write(input logic [3:0] addr, input logic [31:0] data,
                            output int unsigned acc);
    int n;
    n = 0;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) begin
      n++;
      if (n > timeout_lp) stop_on_error("timeout waiting for awready and wready");
      @(negedge clk);
    end
    acc = cycle;
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  // bready stays low for fewer than max_hold cycles while bresp must hold still
  task automatic take_bresp(input int unsigned max_hold, output logic [1:0] resp);
    int n;
    n = 0;
    @(negedge clk);
    while (!bvalid) begin
      n++;
      if (n > timeout_lp) stop_on_error("timeout waiting for bvalid");
      @(negedge clk);
    end
    resp = bresp;
    repeat ($urandom % max_hold) begin
      @(negedge clk);
      if (!bvalid || bresp !== resp) stop_on_error("write response changed before bready");
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int unsigned acc;
    send_write(addr, data, acc);
    take_bresp(4, resp);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    n = 0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) begin
      n++;
      if (n > timeout_lp) stop_on_error("timeout waiting for arready");
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!rvalid) begin
      n++;
      if (n > timeout_lp) stop_on_error("timeout waiting for rvalid");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    // rready stays low for a while and the r payload must not move
    repeat ($urandom % 4) begin
      @(negedge clk);
      if (!rvalid || rdata !== data || rresp !== resp) begin
        stop_on_error("read data changed before rready");
      end
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic write_and_check(input logic [3:0] addr, input logic [31:0] data,
                                 input logic [1:0] exp_resp);
    logic [1:0] resp;
    write_reg(addr, data, resp);
    compare_resp("bresp", exp_resp, resp);
  endtask

  // mask keeps only the bits with a known value
  task automatic read_and_check(input logic [3:0] addr, input logic [31:0] exp_data,
                                input logic [31:0] mask, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    compare_resp("rresp", exp_resp, resp);
    compare_word("rdata", exp_data, data & mask);
  endtask

  task automatic wait_write_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!(awvalid && awready)) begin
      n++;
      if (n > timeout_lp) stop_on_error("timeout waiting for the operand write to be taken");
      @(negedge clk);
    end
  endtask

  // ----------------------------------------------------------------------------
  // conversions
  // ----------------------------------------------------------------------------

  // poll for done and then hand operand, mode, result and status to the checker
  task automatic collect_result(input logic [31:0] value, input logic [2:0] mode);
    logic [31:0] status;
    logic [31:0] result;
    logic [1:0]  resp;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[2]) begin
      polls++;
      if (polls > poll_max_lp) stop_on_error("timeout waiting for status done");
      read_reg(e_reg_status, status, resp);
      compare_resp("rresp", 2'b00, resp);
    end
    read_reg(e_reg_result, result, resp);
    compare_resp("rresp", 2'b00, resp);
    op_q.push_back(value);
    mode_q.push_back(mode);
    res_q.push_back(result);
    stat_q.push_back(status);
    -> conv_ev;
  endtask

  task automatic run_conversion(input logic [31:0] value, input logic [2:0] mode);
    write_and_check(e_reg_ctrl, 32'(mode), 2'b00);
    write_and_check(e_reg_operand, value, 2'b00);
    collect_result(value, mode);
  endtask

  // checker expects done set, busy clear and the reference inexact bit
  always begin
    logic [32:0] expect_v;
    logic [31:0] op;
    logic [2:0]  mode;
    logic [31:0] res;
    logic [31:0] stat;
    @(conv_ev);
    while (op_q.size() > 0) begin
      op       = op_q.pop_front();
      mode     = mode_q.pop_front();
      res      = res_q.pop_front();
      stat     = stat_q.pop_front();
      expect_v = ref_i2f(op, mode);
      compare_word("result", expect_v[31:0], res);
      compare_word("status", {29'b0, 1'b1, expect_v[32], 1'b0}, stat);
    end
  end

  // ----------------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------------

  initial begin
    logic [31:0] value;
    logic [1:0]  resp;
    int unsigned acc1;
    int unsigned acc2;
    logic [31:0] exact_vals[6];
    logic [31:0] round_vals[7];
    void'($urandom(71));
    clk     = 1'b0;
    rst_n   = 1'b0;
    cycle   = 0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // registers come up cleared
    read_and_check(e_reg_ctrl, 32'h0, '1, 2'b00);
    read_and_check(e_reg_result, 32'h0, '1, 2'b00);
    read_and_check(e_reg_status, 32'h0, '1, 2'b00);

    // values that fit in the significand
    exact_vals = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h0100_0000, 32'h8000_0000, 32'h7F};
    foreach (exact_vals[i]) begin
      for (int m = 0; m < 5; m++) begin
        run_conversion(exact_vals[i], 3'(m));
      end
    end

    // tie even, tie odd, sticky only, guard and sticky, tie on even, carry out
    round_vals = '{32'h0100_0001, 32'h0100_0003, 32'h0200_0001, 32'h0200_0003,
                   32'h0200_0002, 32'h01FF_FFFF, 32'h7FFF_FFFF};
    foreach (round_vals[i]) begin
      for (int m = 0; m < 5; m++) begin
        run_conversion(round_vals[i], 3'(m));
        run_conversion(-round_vals[i], 3'(m));
      end
    end

    // random operands with mode codes 5 to 7 included
    for (int i = 0; i < 300; i++) begin
      value = $urandom;
      if ($urandom % 3 == 0) begin
        value = value >> ($urandom % 32);
      end
      run_conversion(value, 3'($urandom % 8));
    end

    // read only and unmapped offsets
    write_and_check(e_reg_ctrl, 32'(e_rdn), 2'b00);
    write_and_check(e_reg_result, 32'h1234_5678, 2'b10);
    write_and_check(e_reg_status, 32'h7, 2'b10);
    write_and_check(4'h2, 32'h1, 2'b10);
    read_and_check(e_reg_ctrl, 32'(e_rdn), '1, 2'b00);
    read_and_check(4'h6, 32'h0, '1, 2'b10);

    // back to back operands where the second one stalls behind busy
    write_and_check(e_reg_ctrl, 32'(e_rne), 2'b00);
    fork
      begin
        send_write(e_reg_operand, 32'h0123_4567, acc1);
        send_write(e_reg_operand, 32'hF000_0001, acc2);
      end
      begin
        // first response taken at once so only busy holds the second write back
        take_bresp(1, resp);
        compare_resp("bresp", 2'b00, resp);
        take_bresp(4, resp);
        compare_resp("bresp", 2'b00, resp);
      end
      begin
        wait_write_accept();
        // busy set and done cleared while inexact still holds the previous value
        read_and_check(e_reg_status, 32'h1, 32'h5, 2'b00);
      end
    join
    // done lands 3 cycles after the first accept and the stalled write goes in on the next edge
    if (acc2 != acc1 + 4) begin
      stop_on_error("second operand not taken right after the first result was done");
    end
    collect_result(32'hF000_0001, 3'(e_rne));

    repeat (2) @(posedge clk);
    if (op_q.size() != 0) begin
      stop_on_error("conversions left unchecked at the end of the run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
